/* src.f */
+incdir+source
source/raster_pkg.sv
source/model_buffer.sv
source/model_walker.sv
source/triangle_setup.sv
source/model_store_top.sv
tb/model_store_tb.sv

/* Bender.yml */
package:
  name: model_store

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/raster_pkg.sv
      - source/model_buffer.sv
      - source/model_walker.sv
      - source/triangle_setup.sv
      - source/model_store_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/model_store_tb.sv

/* tb/model_store_tb.sv */
`timescale 1ns/1ps
`include "raster_settings.svh"

module model_store_tb;

    localparam int WRITE_COUNT   = 64;   // Accepted writes over the whole run
    localparam int DRAW_COUNT    = 17;
    localparam int LARGEST_MODEL = 35;
    localparam int CYCLE_LIMIT   = 2 * WRITE_COUNT + DRAW_COUNT * LARGEST_MODEL + 400;

    logic                        clk;
    logic                        rstn;
    logic                        write_valid;
    logic                        write_ready;
    raster_pkg::modelbuf_write_t write_data;
    logic                        draw_valid;
    logic                        draw_ready;
    raster_pkg::model_id_t       draw_model;
    logic                        out_valid;
    logic                        out_ready;
    raster_pkg::setup_out_t      out_data;

    // Reference model of the store kept from accepted writes
    raster_pkg::triangle_t sb_tri [`MODEL_COUNT][`TRIANGLE_COUNT];
    raster_pkg::tri_idx_t  sb_size [`MODEL_COUNT];
    logic                  sb_closed [`MODEL_COUNT];
    logic                  sb_open_valid;
    raster_pkg::model_id_t sb_open_id;
    int                    sb_used;

    raster_pkg::model_id_t exp_model_q [$];   // Triangles still owed to the output
    raster_pkg::tri_idx_t  exp_index_q [$];
    logic                  exp_valid;
    raster_pkg::model_id_t exp_model;
    raster_pkg::tri_idx_t  exp_index;
    raster_pkg::triangle_t exp_tri;
    logic                  exp_last;
    logic                  draw_busy_exp;

    int          pending_count;
    int          write_count;
    int          draw_count;
    int          cycle_count;
    logic        timed_out;
    logic        write_ok_exp;
    logic        silent_expect;
    logic        stall_on;
    logic [31:0] lfsr_state;
    int          err_write;
    int          err_order;
    int          err_data;
    int          err_last;
    int          err_bbox;
    int          err_hold;
    int          err_silent;
    int          err_draw;
    int          err_other;

    model_store_top model_store_top_inst (
        .clk         (clk),
        .rstn        (rstn),
        .write_valid (write_valid),
        .write_ready (write_ready),
        .write_data  (write_data),
        .draw_valid  (draw_valid),
        .draw_ready  (draw_ready),
        .draw_model  (draw_model),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) value = {value[30:0], lfsr_bit()};
        return value;
    endfunction

    function automatic raster_pkg::triangle_t random_triangle();
        raster_pkg::triangle_t t;
        t.v0.x = `COORD_W'(random_bits(`COORD_W));
        t.v0.y = `COORD_W'(random_bits(`COORD_W));
        t.v1.x = `COORD_W'(random_bits(`COORD_W));
        t.v1.y = `COORD_W'(random_bits(`COORD_W));
        t.v2.x = `COORD_W'(random_bits(`COORD_W));
        t.v2.y = `COORD_W'(random_bits(`COORD_W));
        return t;
    endfunction

    // Expected screen box from a scan over the three corners
    function automatic raster_pkg::bbox_t bbox_of(input raster_pkg::triangle_t t);
        logic signed [`COORD_W-1:0] xs [3];
        logic signed [`COORD_W-1:0] ys [3];
        raster_pkg::bbox_t b;
        xs[0] = t.v0.x;
        xs[1] = t.v1.x;
        xs[2] = t.v2.x;
        ys[0] = t.v0.y;
        ys[1] = t.v1.y;
        ys[2] = t.v2.y;
        b = '{x_min: xs[0], x_max: xs[0], y_min: ys[0], y_max: ys[0]};
        for (int i = 1; i < 3; i++) begin
            if ($signed(xs[i]) < $signed(b.x_min)) b.x_min = xs[i];
            if ($signed(xs[i]) > $signed(b.x_max)) b.x_max = xs[i];
            if ($signed(ys[i]) < $signed(b.y_min)) b.y_min = ys[i];
            if ($signed(ys[i]) > $signed(b.y_max)) b.y_max = ys[i];
        end
        return b;
    endfunction

    // A closed target or a full memory refuses the write
    function automatic logic write_allowed(input raster_pkg::model_id_t id);
        if (sb_closed[id]) return 1'b0;
        if (sb_used >= `TRIANGLE_COUNT) return 1'b0;
        return 1'b1;
    endfunction

    always @(posedge clk or negedge rstn) begin : monitor
        raster_pkg::model_id_t wid;
        if (!rstn) begin
            exp_model_q.delete();
            exp_index_q.delete();
            for (int i = 0; i < `MODEL_COUNT; i++) begin
                sb_size[i]   = '0;
                sb_closed[i] = 1'b0;
            end
            sb_open_valid = 1'b0;
            sb_open_id    = '0;
            sb_used       = 0;
            pending_count = 0;
            write_count   = 0;
            draw_count    = 0;
            exp_valid    <= 1'b0;
        end else begin
            // Draw sees the registry as it was before this edge
            if (draw_valid && draw_ready) begin
                draw_count++;
                draw_busy_exp <= sb_closed[draw_model];   // Closed models are never empty
                if (sb_closed[draw_model]) begin
                    for (int i = 0; i < sb_size[draw_model]; i++) begin
                        exp_model_q.push_back(draw_model);
                        exp_index_q.push_back(raster_pkg::tri_idx_t'(i));
                    end
                end
            end
            if (write_valid && write_ready) begin
                wid = write_data.model_id;
                if (sb_open_valid && sb_open_id != wid) sb_closed[sb_open_id] = 1'b1;
                sb_tri[wid][sb_size[wid]] = write_data.triangle;
                sb_size[wid]  = sb_size[wid] + 1'b1;
                sb_used++;
                sb_open_valid = !write_data.close;
                sb_open_id    = wid;
                if (write_data.close) sb_closed[wid] = 1'b1;
                write_count++;
            end
            if (out_valid && out_ready && exp_model_q.size() != 0) begin
                void'(exp_model_q.pop_front());
                void'(exp_index_q.pop_front());
            end
            pending_count = exp_model_q.size();
            exp_valid    <= (pending_count != 0);
            if (pending_count != 0) begin
                exp_model <= exp_model_q[0];
                exp_index <= exp_index_q[0];
                exp_tri   <= sb_tri[exp_model_q[0]][exp_index_q[0]];
                exp_last  <= (raster_pkg::tri_idx_t'(exp_index_q[0] + 1'b1)
                              == sb_size[exp_model_q[0]]);
            end
        end
    end

    always @(negedge clk) begin
        out_ready = stall_on ? lfsr_bit() : 1'b1;   // Random back-pressure
    end

    write_ready_a: assert property (@(posedge clk) disable iff (!rstn)
        write_valid |-> write_ready == write_ok_exp)
        else begin
            err_write++;
            $display("** Error: write_ready = 0x%h, expected 0x%h",
                     $sampled(write_ready), $sampled(write_ok_exp));
        end

    draw_ready_a: assert property (@(posedge clk) disable iff (!rstn)
        draw_valid && draw_ready |=> draw_ready == !draw_busy_exp)
        else begin
            err_draw++;
            $display("** Error: draw_ready = 0x%h after a draw, expected 0x%h",
                     $sampled(draw_ready), $sampled(!draw_busy_exp));
        end

    out_expected_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready |-> exp_valid)
        else begin
            err_order++;
            $display("Output delivered a triangle while none was expected");
        end

    out_model_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready && exp_valid |-> out_data.meta.model_id == exp_model)
        else begin
            err_order++;
            $display("** Error: out_data.meta.model_id = 0x%h, expected 0x%h",
                     $sampled(out_data.meta.model_id), $sampled(exp_model));
        end

    out_index_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready && exp_valid |-> out_data.meta.triangle_index == exp_index)
        else begin
            err_order++;
            $display("** Error: out_data.meta.triangle_index = 0x%h, expected 0x%h",
                     $sampled(out_data.meta.triangle_index), $sampled(exp_index));
        end

    out_triangle_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready && exp_valid |-> out_data.triangle == exp_tri)
        else begin
            err_data++;
            $display("** Error: out_data.triangle = 0x%h, expected 0x%h",
                     $sampled(out_data.triangle), $sampled(exp_tri));
        end

    out_last_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready && exp_valid |-> out_data.meta.last == exp_last)
        else begin
            err_last++;
            $display("** Error: out_data.meta.last = 0x%h, expected 0x%h",
                     $sampled(out_data.meta.last), $sampled(exp_last));
        end

    out_bbox_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> out_data.bbox == bbox_of(out_data.triangle))
        else begin
            err_bbox++;
            $display("** Error: out_data.bbox = 0x%h, expected 0x%h",
                     $sampled(out_data.bbox), bbox_of($sampled(out_data.triangle)));
        end

    out_hold_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            err_hold++;
            $display("** Error: out_data = 0x%h while stalled, expected 0x%h",
                     $sampled(out_data), $past(out_data));
        end

    silent_a: assert property (@(posedge clk) disable iff (!rstn)
        silent_expect |-> !out_valid)
        else begin
            err_silent++;
            $display("** Error: out_valid = 0x%h during an empty draw, expected 0x0",
                     $sampled(out_valid));
        end

    task automatic write_tri(input raster_pkg::model_id_t id, input logic close);
        int n;
        n = write_count;
        write_data   = '{model_id: id, close: close, triangle: random_triangle()};
        write_ok_exp = write_allowed(id);
        write_valid  = 1'b1;
        do begin
            @(negedge clk);
        end while (write_count == n);
        write_valid = 1'b0;
    endtask

    task automatic write_model(input raster_pkg::model_id_t id, input int count,
                               input logic close_last);
        for (int i = 0; i < count; i++) begin
            write_tri(id, close_last && (i == count - 1));
            if (lfsr_bit()) @(negedge clk);   // Occasional idle gap
        end
    endtask

    task automatic refuse_write(input raster_pkg::model_id_t id);
        int n;
        n = write_count;
        write_data   = '{model_id: id, close: 1'b0, triangle: random_triangle()};
        write_ok_exp = write_allowed(id);
        write_valid  = 1'b1;
        repeat (4) @(negedge clk);
        write_valid = 1'b0;   // Withdraw the blocked record
        if (write_count != n) begin
            err_other++;
            $display("Write to model %0d was accepted although it should stay blocked", id);
        end
    endtask

    task automatic draw(input raster_pkg::model_id_t id);
        int n;
        n = draw_count;
        draw_model = id;
        draw_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (draw_count == n);
        draw_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending_count != 0 || out_valid) @(negedge clk);
    endtask

    task automatic silent_draw(input raster_pkg::model_id_t id);
        wait_drain();
        silent_expect = 1'b1;
        draw(id);
        while (!draw_ready) @(negedge clk);
        repeat (6) @(negedge clk);
        silent_expect = 1'b0;
    endtask

    task automatic finish_run();
        int total;
        total = err_write + err_order + err_data + err_last + err_bbox + err_hold
                + err_silent + err_draw + err_other;
        $write("Errors: write %0d, order %0d, data %0d, last %0d, bbox %0d, ",
               err_write, err_order, err_data, err_last, err_bbox);
        $display("hold %0d, silent %0d, draw %0d, other %0d",
                 err_hold, err_silent, err_draw, err_other);
        if (total == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    initial begin
        cycle_count = 0;
        timed_out   = 1'b0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        timed_out = 1'b1;
        $display("Timeout: run reached %0d cycles with %0d triangles still expected",
                 CYCLE_LIMIT, pending_count);
        finish_run();
    end

    initial begin
        lfsr_state    = 32'he47f46ac;
        err_write     = 0;
        err_order     = 0;
        err_data      = 0;
        err_last      = 0;
        err_bbox      = 0;
        err_hold      = 0;
        err_silent    = 0;
        err_draw      = 0;
        err_other     = 0;
        draw_busy_exp = 1'b0;
        rstn          = 1'b0;
        write_valid   = 1'b0;
        write_data    = '0;
        write_ok_exp  = 1'b1;
        draw_valid    = 1'b0;
        draw_model    = '0;
        out_ready     = 1'b1;
        stall_on      = 1'b0;
        silent_expect = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        write_model(0, 5, 1'b0);   // Closed by the switch to model 1
        write_model(1, 7, 1'b1);
        write_model(2, 4, 1'b0);
        write_model(3, 6, 1'b1);
        draw(0);
        draw(2);
        draw(1);
        draw(3);
        wait_drain();

        refuse_write(1);
        refuse_write(0);
        draw(0);
        draw(1);

        silent_draw(4);            // Never written
        write_model(5, 3, 1'b0);
        silent_draw(5);            // Still open
        write_model(5, 3, 1'b1);
        draw(5);

        write_model(6, 35, 1'b1);
        write_model(7, 1, 1'b0);   // Memory now full and model 7 stays open
        refuse_write(7);
        refuse_write(4);
        refuse_write(6);
        silent_draw(7);
        draw(6);
        wait_drain();

        stall_on = 1'b1;
        draw(0);
        draw(5);
        draw(1);
        draw(6);
        draw(2);
        draw(3);
        wait_drain();
        stall_on = 1'b0;
        repeat (2) @(negedge clk);
        finish_run();
    end

endmodule

/* source/model_store_top.sv */
`timescale 1ns/1ps

module model_store_top (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic                        write_valid,
    output logic                        write_ready,
    input  raster_pkg::modelbuf_write_t write_data,

    input  logic                        draw_valid,
    output logic                        draw_ready,
    input  raster_pkg::model_id_t       draw_model,

    output logic                        out_valid,
    input  logic                        out_ready,
    output raster_pkg::setup_out_t      out_data
);

    raster_pkg::model_id_t      size_query_id;
    raster_pkg::tri_idx_t       size_query_count;

    logic                       rd_req_valid;
    logic                       rd_req_ready;
    raster_pkg::modelbuf_read_t rd_req_data;

    logic                       rd_valid;
    logic                       rd_ready;
    raster_pkg::triangle_t      rd_triangle;
    raster_pkg::triangle_meta_t rd_meta;

    model_buffer model_buffer_inst (
        .clk              (clk),
        .rstn             (rstn),
        .write_valid      (write_valid),
        .write_ready      (write_ready),
        .write_data       (write_data),
        .rd_req_valid     (rd_req_valid),
        .rd_req_ready     (rd_req_ready),
        .rd_req_data      (rd_req_data),
        .rd_valid         (rd_valid),
        .rd_ready         (rd_ready),
        .rd_triangle      (rd_triangle),
        .rd_meta          (rd_meta),
        .size_query_id    (size_query_id),
        .size_query_count (size_query_count)
    );

    model_walker model_walker_inst (
        .clk              (clk),
        .rstn             (rstn),
        .draw_valid       (draw_valid),
        .draw_ready       (draw_ready),
        .draw_model       (draw_model),
        .size_query_id    (size_query_id),
        .size_query_count (size_query_count),
        .rd_req_valid     (rd_req_valid),
        .rd_req_ready     (rd_req_ready),
        .rd_req_data      (rd_req_data)
    );

    triangle_setup triangle_setup_inst (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (rd_valid),
        .in_ready    (rd_ready),
        .in_triangle (rd_triangle),
        .in_meta     (rd_meta),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data)
    );

endmodule

/* source/triangle_setup.sv */
`timescale 1ns/1ps
`include "raster_settings.svh"

module triangle_setup (
    input  logic                       clk,
    input  logic                       rstn,

    input  logic                       in_valid,
    output logic                       in_ready,
    input  raster_pkg::triangle_t      in_triangle,
    input  raster_pkg::triangle_meta_t in_meta,

    output logic                       out_valid,
    input  logic                       out_ready,
    output raster_pkg::setup_out_t     out_data
);

    raster_pkg::bbox_t bbox;
    logic              in_fire;

    function automatic logic signed [`COORD_W-1:0] min3(
        input logic signed [`COORD_W-1:0] a,
        input logic signed [`COORD_W-1:0] b,
        input logic signed [`COORD_W-1:0] c
    );
        logic signed [`COORD_W-1:0] m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic logic signed [`COORD_W-1:0] max3(
        input logic signed [`COORD_W-1:0] a,
        input logic signed [`COORD_W-1:0] b,
        input logic signed [`COORD_W-1:0] c
    );
        logic signed [`COORD_W-1:0] m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Screen bounding box from a signed compare on each axis
    always_comb begin
        bbox.x_min = min3(in_triangle.v0.x, in_triangle.v1.x, in_triangle.v2.x);
        bbox.x_max = max3(in_triangle.v0.x, in_triangle.v1.x, in_triangle.v2.x);
        bbox.y_min = min3(in_triangle.v0.y, in_triangle.v1.y, in_triangle.v2.y);
        bbox.y_max = max3(in_triangle.v0.y, in_triangle.v1.y, in_triangle.v2.y);
    end

    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= '{triangle: in_triangle, bbox: bbox, meta: in_meta};
        end
    end

    out_hold_a: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("triangle_setup: output changed while stalled");

endmodule

/* source/model_walker.sv */
`timescale 1ns/1ps

module model_walker (
    input  logic                       clk,
    input  logic                       rstn,

    input  logic                       draw_valid,
    output logic                       draw_ready,
    input  raster_pkg::model_id_t      draw_model,

    output raster_pkg::model_id_t      size_query_id,
    input  raster_pkg::tri_idx_t       size_query_count,

    output logic                       rd_req_valid,
    input  logic                       rd_req_ready,
    output raster_pkg::modelbuf_read_t rd_req_data
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WALK = 1'b1
    } walk_state_t;

    walk_state_t           state;
    raster_pkg::model_id_t cur_model;
    raster_pkg::tri_idx_t  remaining;   // Requests still to issue
    raster_pkg::tri_idx_t  cur_index;
    logic                  draw_fire;
    logic                  req_fire;

    assign draw_ready    = (state == ST_IDLE);
    assign draw_fire     = draw_valid && draw_ready;

    // Lookup follows the incoming command until it is latched
    assign size_query_id = (state == ST_IDLE) ? draw_model : cur_model;

    assign rd_req_valid  = (state == ST_WALK);
    assign req_fire      = rd_req_valid && rd_req_ready;
    assign rd_req_data   = '{model_index: cur_model, triangle_index: cur_index};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            cur_model <= '0;
            remaining <= '0;
            cur_index <= '0;
        end else if (draw_fire) begin
            cur_model <= draw_model;
            remaining <= size_query_count;
            cur_index <= '0;
            // Nothing to walk for an empty or unclosed model
            state     <= (size_query_count == '0) ? ST_IDLE : ST_WALK;
        end else if (req_fire) begin
            cur_index <= cur_index + 1'b1;
            remaining <= remaining - 1'b1;
            if (remaining == raster_pkg::tri_idx_t'(1)) begin
                state <= ST_IDLE;   // Last request just went out
            end
        end
    end

    idle_no_req_a: assert property (@(posedge clk) disable iff (!rstn)
        (state == ST_IDLE) |-> !rd_req_valid)
        else $error("model_walker: read request while idle");

endmodule

/* source/model_buffer.sv */
`timescale 1ns/1ps
`include "raster_settings.svh"

module model_buffer (
    input  logic                       clk,
    input  logic                       rstn,

    input  logic                       write_valid,
    output logic                       write_ready,
    input  raster_pkg::modelbuf_write_t write_data,

    input  logic                       rd_req_valid,
    output logic                       rd_req_ready,
    input  raster_pkg::modelbuf_read_t rd_req_data,

    output logic                       rd_valid,
    input  logic                       rd_ready,
    output raster_pkg::triangle_t      rd_triangle,
    output raster_pkg::triangle_meta_t rd_meta,

    input  raster_pkg::model_id_t      size_query_id,
    output raster_pkg::tri_idx_t       size_query_count
);

    localparam int ADDR_W = $clog2(`TRIANGLE_COUNT);

    typedef enum logic [1:0] {
        ST_EMPTY   = 2'b00,
        ST_WRITING = 2'b01,
        ST_CLOSED  = 2'b10
    } model_state_t;

    typedef struct packed {
        raster_pkg::tri_idx_t start;  // First address in triangle memory
        raster_pkg::tri_idx_t size;
        model_state_t         state;
    } registry_entry_t;

    registry_entry_t       registry [`MODEL_COUNT];
    raster_pkg::triangle_t tri_mem [`TRIANGLE_COUNT];

    raster_pkg::tri_idx_t  next_free;     // Models are packed from address 0 upwards
    logic                  open_valid;    // Some model is currently being written
    raster_pkg::model_id_t open_id;

    registry_entry_t       wr_entry;
    registry_entry_t       wr_entry_next;
    logic                  write_fire;
    logic                  switch_close;

    registry_entry_t       rd_entry;
    raster_pkg::tri_idx_t  rd_addr;
    logic                  rd_req_fire;
    logic                  rd_last;

    // Write side
    // Only one model can be in the writing state, and it always sits at the
    // top of memory, so every accepted write lands on next_free
    always_comb begin
        wr_entry      = registry[write_data.model_id];
        write_ready   = (wr_entry.state != ST_CLOSED) && (next_free < `TRIANGLE_COUNT);
        write_fire    = write_valid && write_ready;
        switch_close  = open_valid && (open_id != write_data.model_id);

        wr_entry_next = wr_entry;
        if (wr_entry.state == ST_EMPTY) begin
            wr_entry_next.start = next_free;   // Open the model here
            wr_entry_next.size  = raster_pkg::tri_idx_t'(1);
        end else begin
            wr_entry_next.size  = wr_entry.size + 1'b1;
        end
        // The close record still carries a triangle of its own
        wr_entry_next.state = write_data.close ? ST_CLOSED : ST_WRITING;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            next_free  <= '0;
            open_valid <= 1'b0;
            open_id    <= '0;
            for (int i = 0; i < `MODEL_COUNT; i++) begin
                registry[i] <= '{start: '0, size: '0, state: ST_EMPTY};
            end
        end else if (write_fire) begin
            // First write to another id ends the previous model
            if (switch_close) begin
                registry[open_id].state <= ST_CLOSED;
            end
            registry[write_data.model_id] <= wr_entry_next;
            next_free  <= next_free + 1'b1;
            open_valid <= !write_data.close;
            open_id    <= write_data.model_id;
        end
    end

    always_ff @(posedge clk) begin
        if (write_fire) begin
            tri_mem[next_free[ADDR_W-1:0]] <= write_data.triangle;
        end
    end

    // Only closed models report a size, so a draw of anything else is empty
    always_comb begin
        if (registry[size_query_id].state == ST_CLOSED) begin
            size_query_count = registry[size_query_id].size;
        end else begin
            size_query_count = '0;
        end
    end

    // Read side
    always_comb begin
        rd_entry     = registry[rd_req_data.model_index];
        rd_addr      = rd_entry.start + rd_req_data.triangle_index;
        rd_req_ready = !rd_valid || rd_ready;     // Stalled output blocks new requests
        rd_req_fire  = rd_req_valid && rd_req_ready;
        rd_last      = raster_pkg::tri_idx_t'(rd_req_data.triangle_index + 1'b1)
                       == rd_entry.size;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_valid <= 1'b0;
        end else if (rd_req_fire) begin
            rd_valid <= 1'b1;
        end else if (rd_ready) begin
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req_fire) begin
            rd_triangle <= tri_mem[rd_addr[ADDR_W-1:0]];
            rd_meta     <= '{last: rd_last,
                             model_id: rd_req_data.model_index,
                             triangle_index: rd_req_data.triangle_index};
        end
    end

    rd_hold_a: assert property (@(posedge clk) disable iff (!rstn)
        rd_valid && !rd_ready |=> $stable(rd_triangle) && $stable(rd_meta))
        else $error("model_buffer: read data changed while stalled");

    next_free_bound_a: assert property (@(posedge clk) disable iff (!rstn)
        next_free <= `TRIANGLE_COUNT)
        else $error("model_buffer: next free address 0x%0h beyond memory", next_free);

endmodule

/* source/raster_pkg.sv */
`include "raster_settings.svh"

package raster_pkg;

    typedef logic [$clog2(`MODEL_COUNT)-1:0] model_id_t;

    // One extra bit so that a full model count fits
    typedef logic [$clog2(`TRIANGLE_COUNT):0] tri_idx_t;

    typedef struct packed {
        logic signed [`COORD_W-1:0] x;
        logic signed [`COORD_W-1:0] y;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        model_id_t model_id;
        logic      close;     // Last triangle of this model
        triangle_t triangle;
    } modelbuf_write_t;

    typedef struct packed {
        model_id_t model_index;
        tri_idx_t  triangle_index;
    } modelbuf_read_t;

    typedef struct packed {
        logic      last;
        model_id_t model_id;
        tri_idx_t  triangle_index;
    } triangle_meta_t;

    typedef struct packed {
        logic signed [`COORD_W-1:0] x_min;
        logic signed [`COORD_W-1:0] x_max;
        logic signed [`COORD_W-1:0] y_min;
        logic signed [`COORD_W-1:0] y_max;
    } bbox_t;

    typedef struct packed {
        triangle_t      triangle;
        bbox_t          bbox;
        triangle_meta_t meta;
    } setup_out_t;

endpackage

/* source/raster_settings.svh */
`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// One registry slot per model id
`define MODEL_COUNT 8

// Triangle memory depth shared by all models
`define TRIANGLE_COUNT 64

// Signed screen coordinate width
`define COORD_W 16

`endif
